// File: filelist.f
logic/core_pkg.sv
logic/inst_decoder.sv
logic/register_file.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/backend_top.sv
tb/backend_tb.sv

// File: logic/backend_top.sv
`timescale 1ns/10ps

module backend_top (
    input  logic              clk,
    input  logic              rst_i,
    input  core_pkg::issue_t  issue_i,
    output core_pkg::retire_t retire_o,
    output core_pkg::uint_x_t inst_count_o,
    output logic              exit_o
);

    core_pkg::ex_op_t    ex_op;
    core_pkg::mem_op_t   mem_op;
    core_pkg::wb_op_t    wb_op;
    core_pkg::fwd_t      mem_fwd;
    core_pkg::fwd_t      wb_fwd;
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::uint_x_t   rs1_data;
    core_pkg::uint_x_t   rs2_data;
    logic                rf_we;
    core_pkg::reg_addr_t rf_waddr;
    core_pkg::uint_x_t   rf_wdata;

    inst_decoder u_decoder (
        .clk     (clk),
        .rst_i   (rst_i),
        .issue_i (issue_i),
        .ex_op_o (ex_op)
    );

    register_file u_regfile (
        .clk      (clk),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_i      (rst_i),
        .ex_op_i    (ex_op),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .mem_fwd_i  (mem_fwd),
        .wb_fwd_i   (wb_fwd),
        .mem_op_o   (mem_op)
    );

    memory_stage u_memory (
        .clk       (clk),
        .rst_i     (rst_i),
        .mem_op_i  (mem_op),
        .mem_fwd_o (mem_fwd),
        .wb_op_o   (wb_op)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .rst_i        (rst_i),
        .wb_op_i      (wb_op),
        .wb_fwd_o     (wb_fwd),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata),
        .retire_o     (retire_o),
        .inst_count_o (inst_count_o),
        .exit_o       (exit_o)
    );

endmodule

// File: logic/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);
    localparam logic [31:0] EXIT_PC = 32'hffffff00;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    typedef logic [XLEN-1:0] uint_x_t;
    typedef logic [31:0]     inst_pc_t;
    typedef logic [7:0]      iid_t;
    typedef logic [4:0]      reg_addr_t;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
    } inst_word_u;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    typedef enum logic [0:0] {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      mem_wen;
        wb_sel_e   wb_sel;
        logic      rf_wen;
        reg_addr_t wb_addr;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        inst_pc_t   pc;
        inst_word_u inst;
        iid_t       inst_id;
    } issue_t;

    typedef struct packed {
        logic     valid;
        inst_pc_t pc;
        iid_t     inst_id;
        ctrl_t    ctrl;
        uint_x_t  imm;
    } ex_op_t;

    typedef struct packed {
        logic     valid;
        inst_pc_t pc;
        iid_t     inst_id;
        ctrl_t    ctrl;
        uint_x_t  alu_out;
        uint_x_t  store_data;
    } mem_op_t;

    typedef struct packed {
        logic     valid;
        inst_pc_t pc;
        iid_t     inst_id;
        ctrl_t    ctrl;
        uint_x_t  alu_out;
        uint_x_t  mem_rdata;
    } wb_op_t;

    typedef struct packed {
        logic      valid;
        logic      rf_wen;
        reg_addr_t wb_addr;
        uint_x_t   data;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        inst_pc_t  pc;
        iid_t      inst_id;
        reg_addr_t rd;
        logic      wen;
        uint_x_t   wdata;
    } retire_t;

endpackage

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  core_pkg::ex_op_t    ex_op_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    input  core_pkg::uint_x_t   rs1_data_i,
    input  core_pkg::uint_x_t   rs2_data_i,
    input  core_pkg::fwd_t      mem_fwd_i,
    input  core_pkg::fwd_t      wb_fwd_i,
    output core_pkg::mem_op_t   mem_op_o
);

    core_pkg::uint_x_t op_a;
    core_pkg::uint_x_t rs2_val;
    core_pkg::uint_x_t op_b;
    core_pkg::uint_x_t alu_out;
    core_pkg::mem_op_t mem_op_q;

    // youngest producer wins, x0 never forwarded
    function automatic core_pkg::uint_x_t resolve(
        input core_pkg::reg_addr_t addr,
        input core_pkg::uint_x_t   rf_data,
        input core_pkg::fwd_t      mem_fwd,
        input core_pkg::fwd_t      wb_fwd
    );
        core_pkg::uint_x_t val;
        if (addr == '0) begin
            val = '0;
        end else if (mem_fwd.valid && mem_fwd.rf_wen && mem_fwd.wb_addr == addr) begin
            val = mem_fwd.data;
        end else if (wb_fwd.valid && wb_fwd.rf_wen && wb_fwd.wb_addr == addr) begin
            val = wb_fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rs1_addr_o = ex_op_i.ctrl.rs1;
    assign rs2_addr_o = ex_op_i.ctrl.rs2;

    assign op_a = resolve(ex_op_i.ctrl.rs1, rs1_data_i, mem_fwd_i, wb_fwd_i);
    assign rs2_val = resolve(ex_op_i.ctrl.rs2, rs2_data_i, mem_fwd_i, wb_fwd_i);
    assign op_b = ex_op_i.ctrl.use_imm ? ex_op_i.imm : rs2_val;

    always_comb begin
        case (ex_op_i.ctrl.alu_op)
            core_pkg::ALU_ADD:    alu_out = op_a + op_b;
            core_pkg::ALU_SUB:    alu_out = op_a - op_b;
            core_pkg::ALU_AND:    alu_out = op_a & op_b;
            core_pkg::ALU_OR:     alu_out = op_a | op_b;
            core_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            core_pkg::ALU_PASS_B: alu_out = op_b;
            default:              alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        mem_op_q <= '{valid: ex_op_i.valid, pc: ex_op_i.pc, inst_id: ex_op_i.inst_id,
                      ctrl: ex_op_i.ctrl, alu_out: alu_out, store_data: rs2_val};
        if (rst_i) begin
            mem_op_q.valid <= 1'b0;
        end
    end

    assign mem_op_o = mem_op_q;

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  logic             clk,
    input  logic             rst_i,
    input  core_pkg::issue_t issue_i,
    output core_pkg::ex_op_t ex_op_o
);

    core_pkg::inst_word_u inst;
    core_pkg::ctrl_t      ctrl;
    core_pkg::uint_x_t    imm;
    core_pkg::ex_op_t     ex_op_q;

    assign inst = issue_i.inst;

    always_comb begin
        // default is a no-op that writes nothing
        ctrl = '0;
        ctrl.alu_op = core_pkg::ALU_ADD;
        ctrl.wb_sel = core_pkg::WB_ALU;
        imm = '0;
        case (inst.r_fmt.opcode)
            core_pkg::OPC_OP: begin
                ctrl.rs1 = inst.r_fmt.rs1;
                ctrl.rs2 = inst.r_fmt.rs2;
                ctrl.wb_addr = inst.r_fmt.rd;
                ctrl.rf_wen = 1'b1;
                case (inst.r_fmt.funct3)
                    core_pkg::F3_ADD_SUB: begin
                        if (inst.r_fmt.funct7 == core_pkg::F7_ALT) begin
                            ctrl.alu_op = core_pkg::ALU_SUB;
                        end else if (inst.r_fmt.funct7 != core_pkg::F7_BASE) begin
                            ctrl.rf_wen = 1'b0;
                        end
                    end
                    core_pkg::F3_XOR: ctrl.alu_op = core_pkg::ALU_XOR;
                    core_pkg::F3_OR:  ctrl.alu_op = core_pkg::ALU_OR;
                    core_pkg::F3_AND: ctrl.alu_op = core_pkg::ALU_AND;
                    default:          ctrl.rf_wen = 1'b0;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                // only addi among the immediate ops
                ctrl.rs1 = inst.i_fmt.rs1;
                ctrl.wb_addr = inst.i_fmt.rd;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen = (inst.i_fmt.funct3 == core_pkg::F3_ADD_SUB);
                imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            end
            core_pkg::OPC_LUI: begin
                ctrl.alu_op = core_pkg::ALU_PASS_B;
                ctrl.wb_addr = inst.i_fmt.rd;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen = 1'b1;
                // u-type immediate spans imm, rs1 and funct3
                imm = {inst.i_fmt.imm, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'h000};
            end
            core_pkg::OPC_LOAD: begin
                ctrl.rs1 = inst.i_fmt.rs1;
                ctrl.wb_addr = inst.i_fmt.rd;
                ctrl.use_imm = 1'b1;
                ctrl.wb_sel = core_pkg::WB_MEM;
                ctrl.rf_wen = (inst.i_fmt.funct3 == core_pkg::F3_WORD);
                imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            end
            core_pkg::OPC_STORE: begin
                ctrl.rs1 = inst.s_fmt.rs1;
                ctrl.rs2 = inst.s_fmt.rs2;
                ctrl.use_imm = 1'b1;
                ctrl.mem_wen = (inst.s_fmt.funct3 == core_pkg::F3_WORD);
                imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_op_q <= '{valid: issue_i.valid, pc: issue_i.pc, inst_id: issue_i.inst_id,
                     ctrl: ctrl, imm: imm};
        if (rst_i) begin
            ex_op_q.valid <= 1'b0;
        end
    end

    assign ex_op_o = ex_op_q;

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  core_pkg::mem_op_t mem_op_i,
    output core_pkg::fwd_t    mem_fwd_o,
    output core_pkg::wb_op_t  wb_op_o
);

    core_pkg::uint_x_t dmem [core_pkg::DMEM_WORDS];
    logic [core_pkg::DMEM_AW-1:0] word_idx;
    logic is_load;
    core_pkg::wb_op_t wb_op_q;

    // byte address, word aligned
    assign word_idx = mem_op_i.alu_out[2 +: core_pkg::DMEM_AW];
    assign is_load = (mem_op_i.ctrl.wb_sel == core_pkg::WB_MEM);

    always_ff @(posedge clk) begin
        if (mem_op_i.valid && mem_op_i.ctrl.mem_wen) begin
            dmem[word_idx] <= mem_op_i.store_data;
        end
    end

    // load data is not ready until write-back
    always_comb begin
        mem_fwd_o.valid = mem_op_i.valid && !is_load;
        mem_fwd_o.rf_wen = mem_op_i.ctrl.rf_wen;
        mem_fwd_o.wb_addr = mem_op_i.ctrl.wb_addr;
        mem_fwd_o.data = mem_op_i.alu_out;
    end

    always_ff @(posedge clk) begin
        wb_op_q.pc <= mem_op_i.pc;
        wb_op_q.inst_id <= mem_op_i.inst_id;
        wb_op_q.ctrl <= mem_op_i.ctrl;
        wb_op_q.alu_out <= mem_op_i.alu_out;
        // read every cycle, old data on a same-edge store
        wb_op_q.mem_rdata <= dmem[word_idx];
        if (rst_i) begin
            wb_op_q.valid <= 1'b0;
        end else begin
            wb_op_q.valid <= mem_op_i.valid;
        end
    end

    assign wb_op_o = wb_op_q;

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                clk,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    output core_pkg::uint_x_t   rdata1_o,
    output core_pkg::uint_x_t   rdata2_o,
    input  logic                we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::uint_x_t   wdata_i
);

    core_pkg::uint_x_t regs [32];

    always_ff @(posedge clk) begin
        // x0 stays hardwired
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

// File: logic/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  core_pkg::wb_op_t    wb_op_i,
    output core_pkg::fwd_t      wb_fwd_o,
    output logic                rf_we_o,
    output core_pkg::reg_addr_t rf_waddr_o,
    output core_pkg::uint_x_t   rf_wdata_o,
    output core_pkg::retire_t   retire_o,
    output core_pkg::uint_x_t   inst_count_o,
    output logic                exit_o
);

    core_pkg::uint_x_t wb_data;
    core_pkg::iid_t    saved_id_q;
    logic              id_seen_q;
    logic              is_new_inst;
    core_pkg::uint_x_t inst_count_q;
    core_pkg::retire_t retire_q;
    logic              exit_q;

    assign wb_data = (wb_op_i.ctrl.wb_sel == core_pkg::WB_MEM) ? wb_op_i.mem_rdata
                                                               : wb_op_i.alu_out;

    // a replayed id is dropped
    assign is_new_inst = wb_op_i.valid && (!id_seen_q || saved_id_q != wb_op_i.inst_id);

    assign rf_we_o = is_new_inst && wb_op_i.ctrl.rf_wen && wb_op_i.ctrl.wb_addr != '0;
    assign rf_waddr_o = wb_op_i.ctrl.wb_addr;
    assign rf_wdata_o = wb_data;

    assign wb_fwd_o = '{valid: is_new_inst, rf_wen: wb_op_i.ctrl.rf_wen,
                        wb_addr: wb_op_i.ctrl.wb_addr, data: wb_data};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_seen_q <= 1'b0;
            inst_count_q <= '0;
            exit_q <= 1'b0;
        end else begin
            if (wb_op_i.valid) begin
                id_seen_q <= 1'b1;
                saved_id_q <= wb_op_i.inst_id;
            end
            if (is_new_inst) begin
                inst_count_q <= inst_count_q + 1'b1;
            end
            exit_q <= is_new_inst && wb_op_i.pc == core_pkg::EXIT_PC;
        end
    end

    always_ff @(posedge clk) begin
        retire_q <= '{valid: is_new_inst, pc: wb_op_i.pc, inst_id: wb_op_i.inst_id,
                      rd: wb_op_i.ctrl.wb_addr, wen: rf_we_o, wdata: wb_data};
        if (rst_i) begin
            retire_q.valid <= 1'b0;
        end
    end

    assign retire_o = retire_q;
    assign inst_count_o = inst_count_q;
    assign exit_o = exit_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module backend_tb -f filelist.f \
    --Mdir obj_dir -o backend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/backend_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: tb/backend_tb.sv
`timescale 1ns/10ps

module backend_tb;

    logic clk = 1'b0;
    logic rst;
    core_pkg::issue_t  issue;
    core_pkg::retire_t retire;
    core_pkg::uint_x_t inst_count;
    logic              exit_flag;

    core_pkg::uint_x_t  model_regs [32];
    core_pkg::uint_x_t  model_mem [256];
    core_pkg::uint_x_t  model_count;
    core_pkg::iid_t     model_last_id;
    logic               model_id_seen;
    core_pkg::retire_t  exp_q [$];
    core_pkg::retire_t  obs_q [$];
    logic               exit_obs_q [$];
    core_pkg::inst_pc_t pc_next;
    core_pkg::iid_t     id_next;
    int                 err_count;
    int                 check_count;
    int                 seed;

    backend_top dut (
        .clk          (clk),
        .rst_i        (rst),
        .issue_i      (issue),
        .retire_o     (retire),
        .inst_count_o (inst_count),
        .exit_o       (exit_flag)
    );

    always #50 clk = ~clk;

    // retire_o is stable mid-cycle
    always @(negedge clk) begin
        if (retire.valid === 1'b1) begin
            obs_q.push_back(retire);
            exit_obs_q.push_back(exit_flag);
        end else if (exit_flag === 1'b1) begin
            $display("exit_o went high at %0t without a retirement", $time);
            err_count++;
        end
    end

    task automatic check_word(input string name, input core_pkg::uint_x_t got,
                              input core_pkg::uint_x_t exp);
        check_count++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_retire(input core_pkg::retire_t got, input core_pkg::retire_t exp);
        check_word("retire_o.pc", got.pc, exp.pc);
        check_word("retire_o.inst_id", 32'(got.inst_id), 32'(exp.inst_id));
        check_flag("retire_o.wen", got.wen, exp.wen);
        if (exp.wen) begin
            check_word("retire_o.rd", 32'(got.rd), 32'(exp.rd));
            check_word("retire_o.wdata", got.wdata, exp.wdata);
        end
    endtask

    function automatic logic [31:0] alu(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // model runs in issue order, then drives one issue cycle
    task automatic issue_at(input core_pkg::inst_pc_t pc, input logic [31:0] word,
                            input core_pkg::iid_t id);
        core_pkg::retire_t exp;
        core_pkg::uint_x_t a;
        core_pkg::uint_x_t b;
        core_pkg::uint_x_t imm_i;
        core_pkg::uint_x_t addr;
        logic is_new;
        a = model_regs[word[19:15]];
        b = model_regs[word[24:20]];
        imm_i = {{20{word[31]}}, word[31:20]};
        is_new = !model_id_seen || id != model_last_id;
        model_id_seen = 1'b1;
        model_last_id = id;
        exp = '0;
        exp.valid = 1'b1;
        exp.pc = pc;
        exp.inst_id = id;
        exp.rd = word[11:7];
        case (word[6:0])
            7'b0110011: begin
                exp.wen = 1'b1;
                case ({word[31:25], word[14:12]})
                    10'h000: exp.wdata = a + b;
                    10'h100: exp.wdata = a - b;
                    10'h007: exp.wdata = a & b;
                    10'h006: exp.wdata = a | b;
                    10'h004: exp.wdata = a ^ b;
                    default: exp.wen = 1'b0;
                endcase
            end
            7'b0010011: begin
                exp.wen = (word[14:12] == 3'b000);
                exp.wdata = a + imm_i;
            end
            7'b0110111: begin
                exp.wen = 1'b1;
                exp.wdata = {word[31:12], 12'h000};
            end
            7'b0000011: begin
                addr = a + imm_i;
                exp.wen = (word[14:12] == 3'b010);
                exp.wdata = model_mem[addr[9:2]];
            end
            7'b0100011: begin
                addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
                if (word[14:12] == 3'b010) begin
                    model_mem[addr[9:2]] = b;
                end
            end
            default: ;
        endcase
        if (exp.rd == 5'd0) begin
            exp.wen = 1'b0;
        end
        if (is_new) begin
            if (exp.wen) begin
                model_regs[exp.rd] = exp.wdata;
            end
            model_count++;
            exp_q.push_back(exp);
        end
        issue.valid = 1'b1;
        issue.pc = pc;
        issue.inst = word;
        issue.inst_id = id;
        @(posedge clk);
        #1;
        issue.valid = 1'b0;
    endtask

    task automatic issue_inst(input logic [31:0] word);
        issue_at(pc_next, word, id_next);
        pc_next = pc_next + 32'd4;
        id_next = id_next + 8'd1;
    endtask

    task automatic load_const(input logic [4:0] rd, input core_pkg::uint_x_t value);
        core_pkg::uint_x_t upper;
        // round up so the sign-extended addi lands on value
        upper = value + 32'h800;
        issue_inst({upper[31:12], rd, 7'b0110111});
        issue_inst(addi(rd, rd, value[11:0]));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_and_check();
        core_pkg::retire_t got;
        core_pkg::retire_t exp;
        logic got_exit;
        int waited;
        waited = 0;
        while (obs_q.size() < exp_q.size() && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (obs_q.size() < exp_q.size()) begin
            $display("timeout: only %0d of %0d retirements seen", obs_q.size(), exp_q.size());
            err_count++;
        end
        // a replayed id would show up within the fixed latency
        repeat (4) @(posedge clk);
        #1;
        if (obs_q.size() > exp_q.size()) begin
            $display("%0d retirements more than expected", obs_q.size() - exp_q.size());
            err_count++;
        end
        while (exp_q.size() > 0 && obs_q.size() > 0) begin
            exp = exp_q.pop_front();
            got = obs_q.pop_front();
            got_exit = exit_obs_q.pop_front();
            check_retire(got, exp);
            check_flag("exit_o", got_exit, exp.pc == core_pkg::EXIT_PC);
        end
        exp_q.delete();
        obs_q.delete();
        exit_obs_q.delete();
        check_word("inst_count_o", inst_count, model_count);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag("retire_o.valid", retire.valid, 1'b0);
        check_flag("exit_o", exit_flag, 1'b0);
        check_word("inst_count_o", inst_count, 32'd0);
        @(posedge clk);
        #1;
    endtask

    task automatic test_alu_chain();
        int round;
        for (round = 0; round < 3; round++) begin
            load_const(5'd1, $random(seed));
            load_const(5'd2, $random(seed));
            issue_inst(alu(7'h00, 3'h0, 5'd3, 5'd1, 5'd2));
            issue_inst(alu(7'h20, 3'h0, 5'd4, 5'd3, 5'd1));
            // x3 now two back, so write-back path
            issue_inst(alu(7'h00, 3'h7, 5'd5, 5'd4, 5'd3));
            issue_inst(alu(7'h00, 3'h6, 5'd6, 5'd5, 5'd2));
            issue_inst(alu(7'h00, 3'h4, 5'd7, 5'd6, 5'd4));
            issue_inst(addi(5'd8, 5'd7, 12'($random(seed))));
            issue_inst(alu(7'h00, 3'h0, 5'd9, 5'd8, 5'd1));
            drain_and_check();
        end
    endtask

    task automatic test_load_store();
        issue_inst(addi(5'd10, 5'd0, 12'h100));
        load_const(5'd11, $random(seed));
        issue_inst(sw(5'd11, 5'd10, 12'h000));
        load_const(5'd12, $random(seed));
        issue_inst(sw(5'd12, 5'd10, 12'h008));
        issue_inst(sw(5'd12, 5'd10, 12'hffc));
        idle_cycles(2);
        issue_inst(lw(5'd13, 5'd10, 12'h000));
        issue_inst(lw(5'd14, 5'd10, 12'h008));
        // load data only reachable from write-back
        idle_cycles(1);
        issue_inst(alu(7'h00, 3'h0, 5'd15, 5'd13, 5'd14));
        drain_and_check();
    endtask

    task automatic test_duplicate_id();
        core_pkg::inst_pc_t pc;
        core_pkg::iid_t id;
        load_const(5'd16, $random(seed));
        drain_and_check();
        pc = pc_next;
        id = id_next;
        issue_at(pc, addi(5'd16, 5'd16, 12'h123), id);
        issue_at(pc, addi(5'd16, 5'd16, 12'h123), id);
        pc_next = pc_next + 32'd4;
        id_next = id_next + 8'd1;
        drain_and_check();
        issue_inst(addi(5'd17, 5'd16, 12'h000));
        drain_and_check();
    endtask

    task automatic test_x0_and_unknown();
        load_const(5'd20, $random(seed));
        issue_inst(alu(7'h00, 3'h0, 5'd0, 5'd1, 5'd2));
        issue_inst(addi(5'd18, 5'd0, 12'h000));
        issue_inst({12'hfff, 5'd20, 3'b000, 5'd20, 7'b1111111});
        drain_and_check();
        issue_inst(addi(5'd21, 5'd20, 12'h000));
        drain_and_check();
    endtask

    task automatic test_exit_pc();
        issue_inst(addi(5'd22, 5'd0, 12'h005));
        issue_at(core_pkg::EXIT_PC, addi(5'd23, 5'd22, 12'h001), id_next);
        id_next = id_next + 8'd1;
        issue_inst(addi(5'd24, 5'd23, 12'h001));
        drain_and_check();
    endtask

    initial begin
        rst = 1'b1;
        issue = '0;
        err_count = 0;
        check_count = 0;
        seed = 32'hb3c3;
        pc_next = 32'h0000_1000;
        id_next = 8'd0;
        model_count = '0;
        model_id_seen = 1'b0;
        model_last_id = '0;
        model_regs[0] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_alu_chain();
        test_load_store();
        test_duplicate_id();
        test_x0_and_unknown();
        test_exit_pc();
        $display("errors: %0d in %0d checks", err_count, check_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
